// File: tb/axil_cases.txt
# op addr wdata strb ready_delay expected_rdata (hex except ready_delay)
# op: W write, R read, B read and write offered together (read expects old data)
W 00000000 12345678 f 0 00000000
R 00000000 00000000 0 2 12345678
W 00000004 ffffffff f 1 00000000
W 00000004 000000aa 1 0 00000000
W 00000005 0000bb00 1 2 00000000
W 00000007 cc000000 1 0 00000000
R 00000004 00000000 0 3 ccffbbaa
W 00000006 00dd0000 1 0 00000000
R 00000044 00000000 0 0 ccddbbaa
W 0000000a 12340000 3 0 00000000
W 00000008 00005678 3 4 00000000
R 00000008 00000000 0 5 12345678
B 0000000c 0badf00d f 2 00000000
R 0000000c 00000000 0 0 0badf00d
B 00000000 deadbeef f 3 12345678
R 00000000 00000000 0 5 deadbeef
W 00000050 a5a5a5a5 f 0 00000000
R 00000010 00000000 0 1 a5a5a5a5
W 00000014 00000011 f 1 00000000
R 00000054 00000000 0 2 00000011
W 00000018 11223344 6 0 00000000
R 00000018 00000000 0 0 11223344
W 0000003c 87654321 f 5 00000000
R 0000007c 00000000 0 4 87654321

// File: tb.f
src/axil_reg_pkg.sv
src/host_req_if.sv
src/axil_client_adaptor.sv
src/host_reg_bank.sv
src/axil_reg_subsystem.sv
tb/tb_axil_reg_subsystem.sv

// File: Bender.yml
package:
  name: axil_reg_subsystem
  description: "AXI4-Lite register target with a sixteen-word register bank"

dependencies: {}

sources:
  # Package first, then interface, then modules bottom-up
  - src/axil_reg_pkg.sv
  - src/host_req_if.sv
  - src/axil_client_adaptor.sv
  - src/host_reg_bank.sv
  - src/axil_reg_subsystem.sv

  # Testbench, top module tb_axil_reg_subsystem
  - target: test
    files:
      - tb/tb_axil_reg_subsystem.sv

// File: tb/tb_axil_reg_subsystem.sv
`timescale 1ns/1ps

module tb_axil_reg_subsystem;

  localparam int         clk_period_lp = 10;
  localparam logic [1:0] okay_resp_lp  = 2'b00;

  logic        clk_i;
  logic        reset_i;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  // Case table loaded from the data file
  logic [7:0]  op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [3:0]  strb_q[$];
  int          delay_q[$];
  logic [31:0] expect_q[$];
  int          case_count;
  logic        cases_loaded;

  int          fd;
  int          code;
  int          ch;
  logic [7:0]  op;
  logic [31:0] f_addr;
  logic [31:0] f_data;
  logic [3:0]  f_strb;
  int          f_delay;
  logic [31:0] f_expect;
  int unsigned idle;

  axil_reg_subsystem u_dut
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awprot_i  (3'b000),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arprot_i  (3'b000),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  task check_value(input string name, input logic [31:0] expected, input logic [31:0] observed);
    if (observed !== expected)
    begin
      $display("ERR %0t %s expected %h observed %h", $time, name, expected, observed);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task next_drive_point;
    @(posedge clk_i);
    #1;
  endtask

  // Nothing new may be accepted while a response is pending
  task check_no_accept;
    check_value("arready", 32'd0, arready);
    check_value("awready", 32'd0, awready);
    check_value("wready", 32'd0, wready);
  endtask

  task wait_read_accept;
    @(negedge clk_i);
    while (!arready)
      @(negedge clk_i);
    check_value("awready", 32'd0, awready);
    check_value("wready", 32'd0, wready);
    next_drive_point();
    arvalid = 1'b0;
  endtask

  task wait_write_accept;
    @(negedge clk_i);
    while (!awready)
      @(negedge clk_i);
    // Address and data go together
    check_value("wready", 32'd1, wready);
    next_drive_point();
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task collect_read_resp(input int delay, input logic [31:0] expected);
    @(negedge clk_i);
    while (!rvalid)
      @(negedge clk_i);
    check_value("rdata", expected, rdata);
    check_no_accept();
    repeat (delay)
    begin
      next_drive_point();
      @(negedge clk_i);
      check_value("rvalid", 32'd1, rvalid);
      check_value("rdata", expected, rdata);
      check_no_accept();
    end
    next_drive_point();
    rready = 1'b1;
    @(negedge clk_i);
    check_value("rvalid", 32'd1, rvalid);
    check_value("rdata", expected, rdata);
    check_value("rresp", okay_resp_lp, rresp);
    check_no_accept();
    next_drive_point();
    rready = 1'b0;
  endtask

  task collect_write_resp(input int delay);
    @(negedge clk_i);
    while (!bvalid)
      @(negedge clk_i);
    check_no_accept();
    repeat (delay)
    begin
      next_drive_point();
      @(negedge clk_i);
      check_value("bvalid", 32'd1, bvalid);
      check_no_accept();
    end
    next_drive_point();
    bready = 1'b1;
    @(negedge clk_i);
    check_value("bvalid", 32'd1, bvalid);
    check_value("bresp", okay_resp_lp, bresp);
    next_drive_point();
    bready = 1'b0;
  endtask

  task axil_read(input logic [31:0] addr, input int delay, input logic [31:0] expected);
    araddr  = addr;
    arvalid = 1'b1;
    wait_read_accept();
    collect_read_resp(delay, expected);
  endtask

  task axil_write(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] strb,
                  input int delay);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    wait_write_accept();
    collect_write_resp(delay);
  endtask

  // Read and write offered in the same cycle, read goes first
  task axil_both(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] strb,
                 input int delay, input logic [31:0] expected);
    araddr  = addr;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    arvalid = 1'b1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    wait_read_accept();
    collect_read_resp(delay, expected);
    wait_write_accept();
    collect_write_resp(delay);
  endtask

  task load_cases;
    fd = $fopen("tb/axil_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the case file tb/axil_cases.txt");
      $display("Regression failed");
      $fatal(1);
    end
    while (!$feof(fd))
    begin
      code = $fscanf(fd, " %c", op);
      if (code != 1)
        break;
      if (op == "#")
      begin
        // Skip the rest of a comment line
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1)
          ch = $fgetc(fd);
      end
      else
      begin
        code = $fscanf(fd, "%h %h %h %d %h", f_addr, f_data, f_strb, f_delay, f_expect);
        if (code != 5 || !(op == "W" || op == "R" || op == "B"))
        begin
          $display("Malformed line in the case file after %0d cases", op_q.size());
          $display("Regression failed");
          $fatal(1);
        end
        op_q.push_back(op);
        addr_q.push_back(f_addr);
        data_q.push_back(f_data);
        strb_q.push_back(f_strb);
        delay_q.push_back(f_delay);
        expect_q.push_back(f_expect);
      end
    end
    $fclose(fd);
    case_count   = op_q.size();
    cases_loaded = 1'b1;
  endtask

  // Watchdog sized from the number of cases
  initial
  begin
    wait (cases_loaded === 1'b1);
    repeat (case_count * 60 + 200) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", case_count * 60 + 200);
    $display("Regression failed");
    $fatal(1);
  end

  initial
  begin
    reset_i      = 1'b1;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    cases_loaded = 1'b0;
    case_count   = 0;
    idle         = $urandom(32'h97f5_2a34);

    load_cases();

    repeat (8) next_drive_point();
    reset_i = 1'b0;

    @(negedge clk_i);
    check_value("bvalid", 32'd0, bvalid);
    check_value("rvalid", 32'd0, rvalid);
    check_value("arready", 32'd0, arready);
    check_value("awready", 32'd0, awready);
    check_value("wready", 32'd0, wready);
    next_drive_point();

    // Every register comes out of reset as zero
    for (int i = 0; i < 16; i++)
      axil_read(i * 4, 0, 32'd0);

    for (int i = 0; i < case_count; i++)
    begin
      idle = $urandom % 4;
      repeat (idle) next_drive_point();
      if (op_q[i] == "W")
        axil_write(addr_q[i], data_q[i], strb_q[i], delay_q[i]);
      else if (op_q[i] == "R")
        axil_read(addr_q[i], delay_q[i], expect_q[i]);
      else
        axil_both(addr_q[i], data_q[i], strb_q[i], delay_q[i], expect_q[i]);
    end

    $display("Regression passed");
    $finish;
  end

endmodule

// File: src/axil_reg_subsystem.sv
`timescale 1ns/1ps

module axil_reg_subsystem
  import axil_reg_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  logic [axil_addr_width_lp-1:0] s_axil_awaddr_i,
  input  logic [2:0]                    s_axil_awprot_i,
  input  logic                          s_axil_awvalid_i,
  output logic                          s_axil_awready_o,

  input  logic [axil_data_width_lp-1:0] s_axil_wdata_i,
  input  logic [axil_strb_width_lp-1:0] s_axil_wstrb_i,
  input  logic                          s_axil_wvalid_i,
  output logic                          s_axil_wready_o,

  output logic [1:0]                    s_axil_bresp_o,
  output logic                          s_axil_bvalid_o,
  input  logic                          s_axil_bready_i,

  input  logic [axil_addr_width_lp-1:0] s_axil_araddr_i,
  input  logic [2:0]                    s_axil_arprot_i,
  input  logic                          s_axil_arvalid_i,
  output logic                          s_axil_arready_o,

  output logic [axil_data_width_lp-1:0] s_axil_rdata_o,
  output logic [1:0]                    s_axil_rresp_o,
  output logic                          s_axil_rvalid_o,
  input  logic                          s_axil_rready_i
);

  // Host request/response link between adaptor and bank
  host_req_if host_if ();

  axil_client_adaptor u_adaptor
  (
    .clk_i,
    .reset_i,
    .s_axil_awaddr_i,
    .s_axil_awprot_i,
    .s_axil_awvalid_i,
    .s_axil_awready_o,
    .s_axil_wdata_i,
    .s_axil_wstrb_i,
    .s_axil_wvalid_i,
    .s_axil_wready_o,
    .s_axil_bresp_o,
    .s_axil_bvalid_o,
    .s_axil_bready_i,
    .s_axil_araddr_i,
    .s_axil_arprot_i,
    .s_axil_arvalid_i,
    .s_axil_arready_o,
    .s_axil_rdata_o,
    .s_axil_rresp_o,
    .s_axil_rvalid_o,
    .s_axil_rready_i,
    .host (host_if.adaptor_mp)
  );

  host_reg_bank u_bank
  (
    .clk_i,
    .reset_i,
    .host (host_if.bank_mp)
  );

endmodule

// File: src/host_reg_bank.sv
`timescale 1ns/1ps

module host_reg_bank
  import axil_reg_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  host_req_if.bank_mp  host
);

  logic [axil_data_width_lp-1:0] regs_r [reg_count_lp];

  logic                          resp_v_r;
  logic [axil_data_width_lp-1:0] rdata_r;

  logic [reg_index_width_lp-1:0] index;
  logic [axil_strb_width_lp-1:0] lane_mask;
  logic                          req_fire;

  // Word index, addresses alias every 64 bytes
  assign index = host.addr[2 +: reg_index_width_lp];

  // Only accept when nothing is waiting to be taken
  assign host.req_ready = ~resp_v_r;
  assign req_fire       = host.req_v && host.req_ready;

  assign host.resp_v = resp_v_r;
  assign host.rdata  = rdata_r;

  // Byte lanes touched by the access
  always_comb
  begin
    case (host.data_size)
      size_byte:
      begin
        lane_mask = 4'b0001 << host.addr[1:0];
      end
      size_half:
      begin
        lane_mask = host.addr[1] ? 4'b1100 : 4'b0011;
      end
      // Dword treated as a full word on this bus
      default:
      begin
        lane_mask = 4'b1111;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      regs_r <= '{default: '0};
    end
    else if (req_fire && host.wr_en)
    begin
      for (int i = 0; i < axil_strb_width_lp; i++)
      begin
        if (lane_mask[i])
        begin
          regs_r[index][8*i +: 8] <= host.wdata[8*i +: 8];
        end
      end
    end
  end

  // One-deep response holding register
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      resp_v_r <= 1'b0;
    end
    else if (req_fire)
    begin
      resp_v_r <= 1'b1;
    end
    else if (host.resp_ready)
    begin
      resp_v_r <= 1'b0;
    end
  end

  // Read data sees the word before this cycle's write
  always_ff @(posedge clk_i)
  begin
    if (req_fire)
    begin
      rdata_r <= host.wr_en ? '0 : regs_r[index];
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    host.resp_v && !host.resp_ready |=> host.resp_v && $stable(host.rdata))
    else $error("Held response changed before it was taken");

endmodule

// File: src/axil_client_adaptor.sv
`timescale 1ns/1ps

module axil_client_adaptor
  import axil_reg_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,

  // Write address channel
  input  logic [axil_addr_width_lp-1:0] s_axil_awaddr_i,
  input  logic [2:0]                    s_axil_awprot_i,
  input  logic                          s_axil_awvalid_i,
  output logic                          s_axil_awready_o,

  // Write data channel
  input  logic [axil_data_width_lp-1:0] s_axil_wdata_i,
  input  logic [axil_strb_width_lp-1:0] s_axil_wstrb_i,
  input  logic                          s_axil_wvalid_i,
  output logic                          s_axil_wready_o,

  // Write response channel
  output logic [1:0]                    s_axil_bresp_o,
  output logic                          s_axil_bvalid_o,
  input  logic                          s_axil_bready_i,

  // Read address channel
  input  logic [axil_addr_width_lp-1:0] s_axil_araddr_i,
  input  logic [2:0]                    s_axil_arprot_i,
  input  logic                          s_axil_arvalid_i,
  output logic                          s_axil_arready_o,

  // Read data channel
  output logic [axil_data_width_lp-1:0] s_axil_rdata_o,
  output logic [1:0]                    s_axil_rresp_o,
  output logic                          s_axil_rvalid_o,
  input  logic                          s_axil_rready_i,

  host_req_if.adaptor_mp                host
);

  axil_state_e state_r;
  axil_state_e state_n;
  host_size_e  wr_size;

  // Strobe pattern to access size, unknown patterns fall back to word
  always_comb
  begin
    case (s_axil_wstrb_i)
      4'h1:    wr_size = size_byte;
      4'h3:    wr_size = size_half;
      4'hF:    wr_size = size_word;
      default: wr_size = size_word;
    endcase
  end

  always_comb
  begin
    state_n = state_r;

    host.req_v      = 1'b0;
    host.addr       = '0;
    host.wr_en      = 1'b0;
    host.data_size  = size_word;
    host.wdata      = '0;
    host.resp_ready = 1'b0;

    s_axil_awready_o = 1'b0;
    s_axil_wready_o  = 1'b0;
    s_axil_arready_o = 1'b0;
    s_axil_bresp_o   = axi_resp_okay_lp;
    s_axil_bvalid_o  = 1'b0;
    s_axil_rdata_o   = '0;
    s_axil_rresp_o   = axi_resp_okay_lp;
    s_axil_rvalid_o  = 1'b0;

    case (state_r)
      st_wait:
      begin
        // Read wins when both are offered
        if (s_axil_arvalid_i)
        begin
          host.req_v       = 1'b1;
          host.addr        = s_axil_araddr_i;
          s_axil_arready_o = host.req_ready;
          if (host.req_ready)
          begin
            state_n = st_read_resp;
          end
        end
        else if (s_axil_awvalid_i && s_axil_wvalid_i)
        begin
          host.req_v       = 1'b1;
          host.addr        = s_axil_awaddr_i;
          host.wr_en       = 1'b1;
          host.data_size   = wr_size;
          host.wdata       = s_axil_wdata_i;
          // Address and data accepted in the same cycle
          s_axil_awready_o = host.req_ready;
          s_axil_wready_o  = host.req_ready;
          if (host.req_ready)
          begin
            state_n = st_write_resp;
          end
        end
      end

      st_read_resp:
      begin
        s_axil_rvalid_o = host.resp_v;
        s_axil_rdata_o  = host.rdata;
        host.resp_ready = s_axil_rready_i;
        if (host.resp_v && s_axil_rready_i)
        begin
          state_n = st_wait;
        end
      end

      st_write_resp:
      begin
        s_axil_bvalid_o = host.resp_v;
        host.resp_ready = s_axil_bready_i;
        if (host.resp_v && s_axil_bready_i)
        begin
          state_n = st_wait;
        end
      end

      default:
      begin
        state_n = st_wait;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= st_wait;
    end
    else
    begin
      state_r <= state_n;
    end
  end

  // Only unprivileged, secure data accesses are supported
  assert property (@(posedge clk_i) disable iff (reset_i)
    (s_axil_awvalid_i |-> s_axil_awprot_i == 3'b000)
    and (s_axil_arvalid_i |-> s_axil_arprot_i == 3'b000))
    else $error("Unsupported AXI protection mode");

  assert property (@(posedge clk_i) disable iff (reset_i)
    !(s_axil_bvalid_o && s_axil_rvalid_o))
    else $error("B and R channels valid together");

endmodule

// File: src/host_req_if.sv
`timescale 1ns/1ps

interface host_req_if
  import axil_reg_pkg::*;
();

  // Request direction, adaptor to bank
  logic                          req_v;
  logic                          req_ready;
  logic [axil_addr_width_lp-1:0] addr;
  logic                          wr_en;
  host_size_e                    data_size;
  logic [axil_data_width_lp-1:0] wdata;

  // Response direction, bank to adaptor
  logic                          resp_v;
  logic                          resp_ready;
  logic [axil_data_width_lp-1:0] rdata;

  modport adaptor_mp
  (
    output req_v, addr, wr_en, data_size, wdata, resp_ready,
    input  req_ready, resp_v, rdata
  );

  modport bank_mp
  (
    input  req_v, addr, wr_en, data_size, wdata, resp_ready,
    output req_ready, resp_v, rdata
  );

endinterface

// File: src/axil_reg_pkg.sv
package axil_reg_pkg;

  // Bus widths
  localparam int axil_data_width_lp = 32;
  localparam int axil_addr_width_lp = 32;
  localparam int axil_strb_width_lp = axil_data_width_lp / 8;

  // Register bank geometry
  // Index comes from address bits 5:2
  localparam int reg_count_lp       = 16;
  localparam int reg_index_width_lp = 4;

  // AXI response codes
  localparam logic [1:0] axi_resp_okay_lp = 2'b00;

  // Host access size
  typedef enum logic [1:0]
  {
    size_byte  = 2'b00,
    size_half  = 2'b01,
    size_word  = 2'b10,
    size_dword = 2'b11
  } host_size_e;

  // Adaptor FSM states
  typedef enum logic [1:0]
  {
    st_wait       = 2'b00,
    st_read_resp  = 2'b01,
    st_write_resp = 2'b10
  } axil_state_e;

endpackage
